//--- logic/cpu_ex.sv
// fritz execute stage
`timescale 1ns/1ns

module cpu_ex (
	input logic clk,
	input logic rst,
	input logic advance,
	input cpu_pkg::word_t rfa,
	input cpu_pkg::word_t rfb,
	input cpu_pkg::word_t operand_b,
	input logic [4:0] shamt,
	input cpu_pkg::func_t func,
	input cpu_pkg::opcode_t op,
	input cpu_pkg::reg_addr_t waddr,
	input cpu_pkg::word_t link,
	input logic rfw,
	input cpu_pkg::wb_src_t wb_src,
	input logic drw,
	output cpu_pkg::word_t x_result,
	output cpu_pkg::word_t x_store_data,
	output cpu_pkg::reg_addr_t x_waddr,
	output cpu_pkg::word_t x_link,
	output logic x_rfw,
	output cpu_pkg::wb_src_t x_wb_src,
	output logic x_drw,
	output logic x_load
);
	cpu_pkg::word_t opb, alu;

	assign opb = (op == cpu_pkg::op_rtype) ? rfb : operand_b;

	always_comb begin
		alu = '0;
		case (op)
			cpu_pkg::op_rtype: begin
				case (func)
					cpu_pkg::fn_sll: alu = opb << shamt; // shifts rt, as in MIPS.
					cpu_pkg::fn_add: alu = rfa + opb;
					cpu_pkg::fn_sub: alu = rfa - opb;
					cpu_pkg::fn_and: alu = rfa & opb;
					cpu_pkg::fn_or: alu = rfa | opb;
					cpu_pkg::fn_slt: alu = {31'd0, $signed(rfa) < $signed(opb)};
					default: alu = '0;
				endcase
			end
			cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw: alu = rfa + opb;
			cpu_pkg::op_andi: alu = rfa & opb;
			cpu_pkg::op_ori: alu = rfa | opb;
			default: alu = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_result <= '0;
			x_store_data <= '0;
			x_waddr <= '0;
			x_link <= '0;
			x_rfw <= 1'b0;
			x_wb_src <= cpu_pkg::wb_alu;
			x_drw <= 1'b0;
			x_load <= 1'b0;
		end else if (advance) begin
			x_result <= alu;
			x_store_data <= rfb;
			x_waddr <= waddr;
			x_link <= link;
			x_rfw <= rfw;
			x_wb_src <= wb_src;
			x_drw <= drw;
			x_load <= (op == cpu_pkg::op_lw);
		end
	end
endmodule

//--- logic/cpu_id.sv
// fritz instruction decode
`timescale 1ns/1ns

module cpu_id (
	input logic clk,
	input logic rst,
	input logic advance,
	input cpu_pkg::word_t pc,
	input cpu_pkg::word_t inst,
	input logic wb_rfw,
	input cpu_pkg::reg_addr_t wb_waddr,
	input cpu_pkg::word_t wb_wdata,
	output logic take_target,
	output cpu_pkg::word_t target,
	output cpu_pkg::word_t p_rfa,
	output cpu_pkg::word_t p_rfb,
	output cpu_pkg::word_t p_operand_b,
	output logic [4:0] p_shamt,
	output cpu_pkg::func_t p_func,
	output cpu_pkg::opcode_t p_op,
	output cpu_pkg::reg_addr_t p_waddr,
	output cpu_pkg::word_t p_link,
	output logic p_rfw,
	output cpu_pkg::wb_src_t p_wb_src,
	output logic p_drw
);
	cpu_pkg::word_t rf [31:1];

	cpu_pkg::opcode_t opcode;
	cpu_pkg::reg_addr_t rs, rt, rd;
	logic [15:0] imm;
	cpu_pkg::word_t rs_val, rt_val, ext_imm, pc_plus4;
	cpu_pkg::reg_addr_t waddr;
	cpu_pkg::wb_src_t wb_src;
	logic rfw, branch, jump;

	assign opcode = cpu_pkg::opcode_t'(inst[31:26]);
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];
	assign imm = inst[15:0];
	assign pc_plus4 = pc + 32'd4;

	assign rs_val = (rs == 5'd0) ? '0 : rf[rs]; // r0 always reads zero.
	assign rt_val = (rt == 5'd0) ? '0 : rf[rt];

	// ##################################################################
	// control decode
	// ##################################################################

	assign ext_imm = (opcode == cpu_pkg::op_andi || opcode == cpu_pkg::op_ori) ?
		{16'h0000, imm} : {{16{imm[15]}}, imm};

	assign rfw = (opcode == cpu_pkg::op_rtype || opcode == cpu_pkg::op_jal ||
		opcode == cpu_pkg::op_jalr || opcode == cpu_pkg::op_addi ||
		opcode == cpu_pkg::op_andi || opcode == cpu_pkg::op_ori ||
		opcode == cpu_pkg::op_lw);

	always_comb begin
		case (opcode)
			cpu_pkg::op_rtype, cpu_pkg::op_jalr: waddr = rd;
			cpu_pkg::op_jal: waddr = 5'd31;
			default: waddr = rt;
		endcase
	end

	assign wb_src = (opcode == cpu_pkg::op_lw) ? cpu_pkg::wb_load :
		(opcode == cpu_pkg::op_jal || opcode == cpu_pkg::op_jalr) ? cpu_pkg::wb_link :
		cpu_pkg::wb_alu;

	// branches and jumps steer the fetch at this advance, so the next word is the delay slot.
	assign branch = (opcode == cpu_pkg::op_beq && rs_val == rt_val) ||
		(opcode == cpu_pkg::op_bne && rs_val != rt_val);
	assign jump = (opcode == cpu_pkg::op_j || opcode == cpu_pkg::op_jal ||
		opcode == cpu_pkg::op_jr || opcode == cpu_pkg::op_jalr);
	assign take_target = branch || jump;

	always_comb begin
		case (opcode)
			cpu_pkg::op_j, cpu_pkg::op_jal: target = {pc_plus4[31:28], inst[25:0], 2'b00};
			cpu_pkg::op_jr, cpu_pkg::op_jalr: target = rs_val;
			default: target = pc_plus4 + {ext_imm[29:0], 2'b00};
		endcase
	end

	// ##################################################################
	// decode/execute register and register file
	// ##################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			p_rfa <= '0;
			p_rfb <= '0;
			p_operand_b <= '0;
			p_shamt <= '0;
			p_func <= cpu_pkg::fn_sll;
			p_op <= cpu_pkg::op_rtype;
			p_waddr <= '0;
			p_link <= '0;
			p_rfw <= 1'b0;
			p_wb_src <= cpu_pkg::wb_alu;
			p_drw <= 1'b0;
		end else if (advance) begin
			p_rfa <= rs_val;
			p_rfb <= rt_val;
			p_operand_b <= ext_imm;
			p_shamt <= inst[10:6];
			p_func <= cpu_pkg::func_t'(inst[5:0]);
			p_op <= opcode;
			p_waddr <= waddr;
			p_link <= pc + 32'd8; // return lands after the delay slot.
			p_rfw <= rfw;
			p_wb_src <= wb_src;
			p_drw <= (opcode == cpu_pkg::op_sw);
		end
	end

	always_ff @(posedge clk) begin
		if (wb_rfw && wb_waddr != 5'd0) rf[wb_waddr] <= wb_wdata;
	end
endmodule

//--- logic/cpu_if.sv
// fritz instruction fetch
`timescale 1ns/1ns

module cpu_if #(
	parameter cpu_pkg::word_t reset_pc = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic take_target,
	input cpu_pkg::word_t target,
	input logic if_ack,
	input cpu_pkg::word_t if_rdata,
	output logic if_req,
	output cpu_pkg::word_t if_addr,
	output cpu_pkg::word_t inst,
	output cpu_pkg::word_t pc,
	output logic done
);
	typedef enum logic [1:0] {idle, wait_ack, wait_release, hold} state_t;

	state_t state;
	cpu_pkg::word_t fetch_pc; // address being fetched this step.
	cpu_pkg::word_t fetch_word;

	assign if_addr = fetch_pc;
	assign done = (state == hold);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			if_req <= 1'b0;
			fetch_pc <= reset_pc;
			inst <= '0; // sll r0 acts as a nop.
			pc <= '0;
		end else begin
			case (state)
				idle: begin
					if_req <= 1'b1;
					state <= wait_ack;
				end
				wait_ack: if (if_ack) begin
					fetch_word <= if_rdata;
					if_req <= 1'b0;
					state <= wait_release;
				end
				wait_release: if (!if_ack) state <= hold;
				hold: if (advance) begin
					inst <= fetch_word; // the fetched word moves on to decode.
					pc <= fetch_pc;
					fetch_pc <= take_target ? target : fetch_pc + 32'd4;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end
endmodule

//--- logic/cpu_mem.sv
// fritz memory and writeback
`timescale 1ns/1ns

module cpu_mem (
	input logic clk,
	input logic rst,
	input logic advance,
	input cpu_pkg::word_t result,
	input cpu_pkg::word_t store_data,
	input cpu_pkg::reg_addr_t waddr,
	input cpu_pkg::word_t link,
	input logic rfw,
	input cpu_pkg::wb_src_t wb_src,
	input logic drw,
	input logic load,
	input logic dm_ack,
	input cpu_pkg::word_t dm_rdata,
	output logic dm_req,
	output logic dm_we,
	output cpu_pkg::word_t dm_addr,
	output cpu_pkg::word_t dm_wdata,
	output logic done,
	output logic wb_rfw,
	output cpu_pkg::reg_addr_t wb_waddr,
	output cpu_pkg::word_t wb_wdata
);
	typedef enum logic [1:0] {idle, wait_ack, wait_release, hold} state_t;

	state_t state;
	cpu_pkg::word_t load_data;
	logic xfer;

	assign xfer = load | drw;
	assign dm_we = drw;
	assign dm_addr = result; // stable for the whole step.
	assign dm_wdata = store_data;
	assign done = (state == hold) || (state == idle && !xfer);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			dm_req <= 1'b0;
		end else begin
			case (state)
				idle: if (xfer) begin
					dm_req <= 1'b1;
					state <= wait_ack;
				end
				wait_ack: if (dm_ack) begin
					load_data <= dm_rdata;
					dm_req <= 1'b0;
					state <= wait_release;
				end
				wait_release: if (!dm_ack) state <= hold;
				hold: if (advance) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	assign wb_rfw = rfw & advance; // one write per instruction.
	assign wb_waddr = waddr;
	assign wb_wdata = (wb_src == cpu_pkg::wb_load) ? load_data :
		(wb_src == cpu_pkg::wb_link) ? link : result;
endmodule

//--- logic/cpu_pkg.sv
// fritz shared types
package cpu_pkg;

	// ##################################################################
	// data words and register numbers
	// ##################################################################

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// ##################################################################
	// instruction encodings
	// ##################################################################

	// primary opcode field, bits 31 to 26.
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j = 6'h02,
		op_jal = 6'h03,
		op_beq = 6'h04,
		op_bne = 6'h05,
		op_jr = 6'h08,
		op_jalr = 6'h09,
		op_addi = 6'h0a,
		op_andi = 6'h0c,
		op_ori = 6'h0d,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_t;

	// function field of R-type words, bits 5 to 0.
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or = 6'h25,
		fn_slt = 6'h2a
	} func_t;

	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_load = 2'd1,
		wb_link = 2'd2
	} wb_src_t;

endpackage

//--- logic/cpu_top.sv
// fritz processor top
`timescale 1ns/1ns

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	output logic mem_req,
	output logic mem_we,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input logic mem_ack,
	input cpu_pkg::word_t mem_rdata
);
	logic advance, if_done, mem_done, take_target;
	logic if_req, if_ack, dm_req, dm_we, dm_ack;
	cpu_pkg::word_t if_addr, if_rdata, dm_addr, dm_wdata, dm_rdata;
	cpu_pkg::word_t inst, pc, target;

	cpu_pkg::word_t p_rfa, p_rfb, p_operand_b, p_link;
	logic [4:0] p_shamt;
	cpu_pkg::func_t p_func;
	cpu_pkg::opcode_t p_op;
	cpu_pkg::reg_addr_t p_waddr;
	cpu_pkg::wb_src_t p_wb_src;
	logic p_rfw, p_drw;

	cpu_pkg::word_t x_result, x_store_data, x_link;
	cpu_pkg::reg_addr_t x_waddr;
	cpu_pkg::wb_src_t x_wb_src;
	logic x_rfw, x_drw, x_load;

	logic wb_rfw;
	cpu_pkg::reg_addr_t wb_waddr;
	cpu_pkg::word_t wb_wdata;

	assign advance = if_done & mem_done; // the whole pipeline steps together.

	cpu_if #(.reset_pc(reset_pc)) i_if (.clk, .rst, .advance, .take_target, .target,
		.if_ack, .if_rdata, .if_req, .if_addr, .inst, .pc, .done(if_done));

	cpu_id i_id (.clk, .rst, .advance, .pc, .inst, .wb_rfw, .wb_waddr, .wb_wdata,
		.take_target, .target, .p_rfa, .p_rfb, .p_operand_b, .p_shamt, .p_func, .p_op,
		.p_waddr, .p_link, .p_rfw, .p_wb_src, .p_drw);

	cpu_ex i_ex (.clk, .rst, .advance, .rfa(p_rfa), .rfb(p_rfb), .operand_b(p_operand_b),
		.shamt(p_shamt), .func(p_func), .op(p_op), .waddr(p_waddr), .link(p_link),
		.rfw(p_rfw), .wb_src(p_wb_src), .drw(p_drw), .x_result, .x_store_data, .x_waddr,
		.x_link, .x_rfw, .x_wb_src, .x_drw, .x_load);

	cpu_mem i_mem (.clk, .rst, .advance, .result(x_result), .store_data(x_store_data),
		.waddr(x_waddr), .link(x_link), .rfw(x_rfw), .wb_src(x_wb_src), .drw(x_drw),
		.load(x_load), .dm_ack, .dm_rdata, .dm_req, .dm_we, .dm_addr, .dm_wdata,
		.done(mem_done), .wb_rfw, .wb_waddr, .wb_wdata);

	mem_arbiter i_arb (.clk, .rst, .if_req, .if_addr, .if_ack, .if_rdata, .dm_req, .dm_we,
		.dm_addr, .dm_wdata, .dm_ack, .dm_rdata, .mem_req, .mem_we, .mem_addr, .mem_wdata,
		.mem_ack, .mem_rdata);
endmodule

//--- logic/mem_arbiter.sv
// fritz memory bus arbiter
`timescale 1ns/1ns

module mem_arbiter (
	input logic clk,
	input logic rst,
	input logic if_req,
	input cpu_pkg::word_t if_addr,
	output logic if_ack,
	output cpu_pkg::word_t if_rdata,
	input logic dm_req,
	input logic dm_we,
	input cpu_pkg::word_t dm_addr,
	input cpu_pkg::word_t dm_wdata,
	output logic dm_ack,
	output cpu_pkg::word_t dm_rdata,
	output logic mem_req,
	output logic mem_we,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input logic mem_ack,
	input cpu_pkg::word_t mem_rdata
);
	typedef enum logic [1:0] {idle, grant_if, grant_dm} grant_t;

	grant_t state, grant;

	// an idle bus passes a new request straight through, data first.
	always_comb begin
		grant = state;
		if (state == idle) begin
			if (dm_req) grant = grant_dm;
			else if (if_req) grant = grant_if;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: state <= grant;
				grant_if: if (!if_req && !mem_ack) state <= idle;
				grant_dm: if (!dm_req && !mem_ack) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	assign mem_req = (grant == grant_dm) ? dm_req : (grant == grant_if) ? if_req : 1'b0;
	assign mem_we = (grant == grant_dm) && dm_we;
	assign mem_addr = (grant == grant_dm) ? dm_addr : if_addr;
	assign mem_wdata = dm_wdata;

	assign if_ack = (grant == grant_if) && mem_ack;
	assign dm_ack = (grant == grant_dm) && mem_ack;
	assign if_rdata = mem_rdata;
	assign dm_rdata = mem_rdata;
endmodule

//--- test/tb_program.svh
// fritz test program and stores
`ifndef tb_program_svh
`define tb_program_svh

	cpu_pkg::word_t program_words [$];
	logic [63:0] expected_stores [$]; // address in the upper half, data in the lower.

	function automatic cpu_pkg::word_t rtype_word(input cpu_pkg::reg_addr_t rs,
		input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd, input logic [4:0] shamt,
		input cpu_pkg::func_t fn);
		return {cpu_pkg::op_rtype, rs, rt, rd, shamt, fn};
	endfunction

	function automatic cpu_pkg::word_t itype_word(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpu_pkg::word_t jump_word(input cpu_pkg::opcode_t op,
		input cpu_pkg::word_t dest);
		return {op, dest[27:2]};
	endfunction

	// program loads at 0x100, data lives from 0x800 on with r10 as base.
	task automatic build_tables();
		program_words.push_back(itype_word(cpu_pkg::op_ori, 5'd0, 5'd1, 16'h1234));
		program_words.push_back(itype_word(cpu_pkg::op_ori, 5'd0, 5'd2, 16'h00f0));
		program_words.push_back(itype_word(cpu_pkg::op_ori, 5'd0, 5'd10, 16'h0800));
		program_words.push_back(itype_word(cpu_pkg::op_addi, 5'd0, 5'd3, 16'hfffb));
		program_words.push_back(32'h0000_0000);
		program_words.push_back(rtype_word(5'd1, 5'd2, 5'd4, 5'd0, cpu_pkg::fn_add));
		program_words.push_back(rtype_word(5'd1, 5'd2, 5'd5, 5'd0, cpu_pkg::fn_sub));
		program_words.push_back(rtype_word(5'd1, 5'd2, 5'd6, 5'd0, cpu_pkg::fn_and));
		program_words.push_back(rtype_word(5'd1, 5'd2, 5'd7, 5'd0, cpu_pkg::fn_or));
		program_words.push_back(rtype_word(5'd3, 5'd1, 5'd8, 5'd0, cpu_pkg::fn_slt));
		program_words.push_back(rtype_word(5'd0, 5'd2, 5'd9, 5'd4, cpu_pkg::fn_sll));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd4, 16'd0));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd5, 16'd4));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd6, 16'd8));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd7, 16'd12));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd8, 16'd16));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd9, 16'd20));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd3, 16'd24));
		program_words.push_back(itype_word(cpu_pkg::op_andi, 5'd3, 5'd11, 16'hff00));
		program_words.push_back(itype_word(cpu_pkg::op_ori, 5'd0, 5'd12, 16'h8001));
		program_words.push_back(itype_word(cpu_pkg::op_addi, 5'd1, 5'd13, 16'h8000));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd1, 16'd28));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd11, 16'd32));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd12, 16'd36));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd13, 16'd40));
		program_words.push_back(itype_word(cpu_pkg::op_lw, 5'd10, 5'd14, 16'd28));
		program_words.push_back(32'h0000_0000);
		program_words.push_back(32'h0000_0000);
		program_words.push_back(32'h0000_0000);
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd14, 16'd44));
		program_words.push_back(itype_word(cpu_pkg::op_beq, 5'd1, 5'd1, 16'd2)); // taken.
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd2, 16'd48));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd3, 16'd52)); // skipped.
		program_words.push_back(itype_word(cpu_pkg::op_bne, 5'd1, 5'd1, 16'd4)); // not taken.
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd6, 16'd52));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd7, 16'd56));
		program_words.push_back(jump_word(cpu_pkg::op_jal, 32'h0000_01a4)); // at 0x190.
		program_words.push_back(itype_word(cpu_pkg::op_ori, 5'd0, 5'd15, 16'h0777));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd31, 16'd60));
		program_words.push_back(jump_word(cpu_pkg::op_j, 32'h0000_019c)); // spins here.
		program_words.push_back(32'h0000_0000);
		program_words.push_back(32'h0000_0000); // subroutine starts at 0x1a4.
		program_words.push_back(32'h0000_0000);
		program_words.push_back(32'h0000_0000);
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd15, 16'd64));
		program_words.push_back(itype_word(cpu_pkg::op_jr, 5'd31, 5'd0, 16'h0000));
		program_words.push_back(itype_word(cpu_pkg::op_sw, 5'd10, 5'd4, 16'd68));

		expected_stores.push_back({32'h0000_0800, 32'h0000_1324});
		expected_stores.push_back({32'h0000_0804, 32'h0000_1144});
		expected_stores.push_back({32'h0000_0808, 32'h0000_0030});
		expected_stores.push_back({32'h0000_080c, 32'h0000_12f4});
		expected_stores.push_back({32'h0000_0810, 32'h0000_0001});
		expected_stores.push_back({32'h0000_0814, 32'h0000_0f00});
		expected_stores.push_back({32'h0000_0818, 32'hffff_fffb}); // addi sign extends.
		expected_stores.push_back({32'h0000_081c, 32'h0000_1234});
		expected_stores.push_back({32'h0000_0820, 32'h0000_ff00}); // andi zero extends.
		expected_stores.push_back({32'h0000_0824, 32'h0000_8001});
		expected_stores.push_back({32'h0000_0828, 32'hffff_9234});
		expected_stores.push_back({32'h0000_082c, 32'h0000_1234}); // value came back from lw.
		expected_stores.push_back({32'h0000_0830, 32'h0000_00f0});
		expected_stores.push_back({32'h0000_0834, 32'h0000_0030});
		expected_stores.push_back({32'h0000_0838, 32'h0000_12f4});
		expected_stores.push_back({32'h0000_0840, 32'h0000_0777});
		expected_stores.push_back({32'h0000_0844, 32'h0000_1324});
		expected_stores.push_back({32'h0000_083c, 32'h0000_0198}); // link is jal plus 8.
	endtask

`endif

//--- test/tb_cpu.sv
// fritz core testbench
`timescale 1ns/1ns

module tb_cpu;
	localparam cpu_pkg::word_t start_pc = 32'h0000_0100;
	localparam cpu_pkg::word_t seed = 32'h2e7f_9606;

	logic clk;
	logic rst;
	logic mem_req;
	logic mem_we;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	logic mem_ack;
	cpu_pkg::word_t mem_rdata;

	cpu_pkg::word_t mem_words [1024]; // covers byte addresses 0 to 0xfff.
	cpu_pkg::word_t rand_state;
	int store_count;
	logic seen_req;
	logic seen_ack;

	`include "tb_program.svh"

	cpu_top #(.reset_pc(start_pc)) i_dut (.clk, .rst, .mem_req, .mem_we, .mem_addr,
		.mem_wdata, .mem_ack, .mem_rdata);

	// ##################################################################
	// checks
	// ##################################################################

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		if (store_count >= expected_stores.size()) begin
			$display("A store to %h came after the last expected store.", addr);
			stop_run();
		end
		check_addr("mem_addr", expected_stores[store_count][63:32], addr);
		check_word("mem_wdata", expected_stores[store_count][31:0], data);
		store_count++;
	endtask

	function automatic cpu_pkg::word_t xorshift(input cpu_pkg::word_t x);
		cpu_pkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ##################################################################
	// clock, memory model and bus monitor
	// ##################################################################

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always begin
		@(posedge clk);
		if (!rst && mem_req) begin
			rand_state = xorshift(rand_state);
			repeat (rand_state % 6) @(posedge clk); // 0 to 5 cycles before ack.
			if (mem_addr[31:12] != '0 || mem_addr[1:0] != 2'b00) begin
				$display("Memory access to %h falls outside the model.", mem_addr);
				stop_run();
			end
			if (mem_we) begin
				mem_words[mem_addr[11:2]] = mem_wdata;
				check_store(mem_addr, mem_wdata);
			end else begin
				mem_rdata <= mem_words[mem_addr[11:2]];
			end
			mem_ack <= 1'b1;
			while (mem_req) @(posedge clk);
			rand_state = xorshift(rand_state);
			repeat (rand_state % 6) @(posedge clk); // ack lingers 0 to 5 cycles after req falls.
			mem_ack <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (!rst && seen_req && !mem_req && !seen_ack) begin
			$display("At %0t ns mem_req dropped before mem_ack was seen.", $time);
			stop_run();
		end
		if (!rst && !seen_req && mem_req && mem_ack) begin
			$display("At %0t ns a new mem_req rose while mem_ack was still high.", $time);
			stop_run();
		end
		seen_req <= mem_req;
		seen_ack <= mem_ack;
	end

	// ##################################################################
	// run control
	// ##################################################################

	initial begin
		rst = 1'b1;
		mem_ack = 1'b0;
		mem_rdata = '0;
		seen_req = 1'b0;
		seen_ack = 1'b0;
		store_count = 0;
		rand_state = seed;
		build_tables();
		for (int i = 0; i < 1024; i++) begin
			mem_words[i] = cpu_pkg::word_t'(i * 4) * 32'h9e37_79b1; // unused words hash their address.
		end
		for (int i = 0; i < program_words.size(); i++) begin
			mem_words[start_pc[11:2] + i] = program_words[i];
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		while (store_count < expected_stores.size()) @(posedge clk);
		$display("Test OK");
		$finish;
	end

	initial begin
		@(negedge rst);
		repeat (400 * program_words.size()) @(posedge clk);
		$display("Watchdog expired after %0d cycles without the last store.",
			400 * program_words.size());
		stop_run();
	end
endmodule

//--- vlog.f
+incdir+test
logic/cpu_pkg.sv
logic/cpu_if.sv
logic/cpu_id.sv
logic/cpu_ex.sv
logic/cpu_mem.sv
logic/mem_arbiter.sv
logic/cpu_top.sv
test/tb_cpu.sv
